//--- Makefile
# Verilator build and run for the transposition table testbench

VERILATOR ?= verilator
TOP       ?= trans_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= RESULT: PASS

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(abspath $(SIM)))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- hw/pos_hash.sv
`timescale 1ns/1ps

module pos_hash
(
   input  logic                                clk,
   input  logic                                reset,

   input  logic                                in_valid,
   output logic                                in_ready,
   input  trans_pkg::trans_op_e                in_op,
   input  logic [trans_pkg::BOARD_WIDTH-1:0]   in_board,
   input  logic                                in_white_to_move,
   input  logic [3:0]                          in_castle_mask,
   input  logic [3:0]                          in_en_passant_col,
   input  logic [trans_pkg::EVAL_WIDTH-1:0]    in_eval,
   input  logic [7:0]                          in_depth,
   input  trans_pkg::bound_flag_e              in_flag,

   output logic                                out_valid,
   input  logic                                out_ready,
   output trans_pkg::trans_op_e                out_op,
   output logic [31:0]                         out_hash,
   output logic [trans_pkg::EVAL_WIDTH-1:0]    out_eval,
   output logic [7:0]                          out_depth,
   output trans_pkg::bound_flag_e              out_flag,

   output logic                                busy
);

   logic v1, v2, v3, v4;
   logic en1, en2, en3, en4;

   // Per-stage key data
   logic [trans_pkg::SIDE_WIDTH-1:0] s1_word [trans_pkg::HASH_LANES];
   logic [31:0] s1_extra;
   logic [31:0] s2_sum_a, s2_sum_b, s2_extra;
   logic [31:0] s3_key;

   // Request fields riding beside the key
   trans_pkg::trans_op_e op1, op2, op3;
   logic white1, white2, white3;
   logic [trans_pkg::EVAL_WIDTH-1:0] eval1, eval2, eval3;
   logic [7:0] depth1, depth2, depth3;
   trans_pkg::bound_flag_e flag1, flag2, flag3;

   // A stage loads when it is empty or its contents move on
   assign en4 = ~v4 | out_ready;
   assign en3 = ~v3 | en4;
   assign en2 = ~v2 | en3;
   assign en1 = ~v1 | en2;

   assign in_ready = en1;
   assign out_valid = v4;
   assign busy = v1 | v2 | v3 | v4;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         v1 <= 1'b0;
         v2 <= 1'b0;
         v3 <= 1'b0;
         v4 <= 1'b0;
      end
      else
      begin
         if (en1) v1 <= in_valid;
         if (en2) v2 <= v1;
         if (en3) v3 <= v2;
         if (en4) v4 <= v3;
      end
   end

   // ========================================
   // Datapath
   // ========================================

   always_ff @(posedge clk)
   begin
      if (en1)
      begin
         for (int i = 0; i < trans_pkg::HASH_LANES; i++)
            s1_word[i] <= trans_pkg::xorshift32(in_board[i*trans_pkg::SIDE_WIDTH +:
                                                          trans_pkg::SIDE_WIDTH]);
         s1_extra <= {28'd0, in_castle_mask ^ in_en_passant_col};
         op1 <= in_op;
         white1 <= in_white_to_move;
         eval1 <= in_eval;
         depth1 <= in_depth;
         flag1 <= in_flag;
      end
      if (en2)
      begin
         s2_sum_a <= s1_word[0] - s1_word[1] + s1_word[2] - s1_word[3];
         s2_sum_b <= s1_word[4] - s1_word[5] + s1_word[6] - s1_word[7];
         s2_extra <= s1_extra;
         {op2, white2, eval2, depth2, flag2} <= {op1, white1, eval1, depth1, flag1};
      end
      if (en3)
      begin
         s3_key <= s2_sum_a + s2_sum_b + s2_extra;
         {op3, white3, eval3, depth3, flag3} <= {op2, white2, eval2, depth2, flag2};
      end
      if (en4)
      begin
         out_hash <= white3 ? trans_pkg::xorshift32(s3_key) : s3_key;  // Side to move
         out_op <= op3;
         out_eval <= eval3;
         out_depth <= depth3;
         out_flag <= flag3;
      end
   end

endmodule

//--- hw/table_ram.sv
`timescale 1ns/1ps

module table_ram
(
   input  logic                                    clk,
   input  logic                                    reset,

   input  logic                                    rd_en,
   input  logic [trans_pkg::TABLE_SIZE_LOG2-1:0]   rd_addr,
   output logic                                    rd_valid,
   output logic [31:0]                             rd_tag,
   output logic [trans_pkg::EVAL_WIDTH-1:0]        rd_eval,
   output logic [7:0]                              rd_depth,
   output trans_pkg::bound_flag_e                  rd_flag,

   input  logic                                    wr_en,
   input  logic [trans_pkg::TABLE_SIZE_LOG2-1:0]   wr_addr,
   input  logic [31:0]                             wr_tag,
   input  logic [trans_pkg::EVAL_WIDTH-1:0]        wr_eval,
   input  logic [7:0]                              wr_depth,
   input  trans_pkg::bound_flag_e                  wr_flag
);

   logic [31:0] tag_mem [trans_pkg::TABLE_SIZE];
   logic [trans_pkg::EVAL_WIDTH-1:0] eval_mem [trans_pkg::TABLE_SIZE];
   logic [7:0] depth_mem [trans_pkg::TABLE_SIZE];
   trans_pkg::bound_flag_e flag_mem [trans_pkg::TABLE_SIZE];

   logic [trans_pkg::TABLE_SIZE-1:0] valid_bits;  // One bit per entry

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid_bits <= '0;
         rd_valid <= 1'b0;
      end
      else
      begin
         if (wr_en) valid_bits[wr_addr] <= 1'b1;
         if (rd_en) rd_valid <= valid_bits[rd_addr];
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         tag_mem[wr_addr] <= wr_tag;
         eval_mem[wr_addr] <= wr_eval;
         depth_mem[wr_addr] <= wr_depth;
         flag_mem[wr_addr] <= wr_flag;
      end
      if (rd_en)
      begin
         rd_tag <= tag_mem[rd_addr];       // Old data on a same-address write
         rd_eval <= eval_mem[rd_addr];
         rd_depth <= depth_mem[rd_addr];
         rd_flag <= flag_mem[rd_addr];
      end
   end

endmodule

//--- hw/trans_ctrl.sv
`timescale 1ns/1ps

module trans_ctrl
(
   input  logic                                    clk,
   input  logic                                    reset,

   input  logic                                    hq_valid,
   output logic                                    hq_ready,
   input  trans_pkg::trans_op_e                    hq_op,
   input  logic [31:0]                             hq_hash,
   input  logic [trans_pkg::EVAL_WIDTH-1:0]        hq_eval,
   input  logic [7:0]                              hq_depth,
   input  trans_pkg::bound_flag_e                  hq_flag,

   output logic                                    rsp_valid,
   input  logic                                    rsp_ready,
   output logic                                    rsp_hit,
   output logic [31:0]                             rsp_hash,
   output logic [trans_pkg::EVAL_WIDTH-1:0]        rsp_eval,
   output logic [7:0]                              rsp_depth,
   output trans_pkg::bound_flag_e                  rsp_flag,

   output logic                                    rd_en,
   output logic [trans_pkg::TABLE_SIZE_LOG2-1:0]   rd_addr,
   input  logic                                    rd_valid,
   input  logic [31:0]                             rd_tag,
   input  logic [trans_pkg::EVAL_WIDTH-1:0]        rd_eval,
   input  logic [7:0]                              rd_depth,
   input  trans_pkg::bound_flag_e                  rd_flag,

   output logic                                    wr_en,
   output logic [trans_pkg::TABLE_SIZE_LOG2-1:0]   wr_addr,
   output logic [31:0]                             wr_tag,
   output logic [trans_pkg::EVAL_WIDTH-1:0]        wr_eval,
   output logic [7:0]                              wr_depth,
   output trans_pkg::bound_flag_e                  wr_flag,

   output logic                                    busy
);

   trans_pkg::ctrl_state_e state;

   // Item being worked on
   trans_pkg::trans_op_e cur_op;
   logic [31:0] cur_hash;
   logic [trans_pkg::EVAL_WIDTH-1:0] cur_eval;
   logic [7:0] cur_depth;
   trans_pkg::bound_flag_e cur_flag;

   logic hit;
   logic replace;

   assign hit = rd_valid && (rd_tag == cur_hash);
   // Only a matching entry that is deeper than the new one survives a store
   assign replace = !hit || (cur_depth >= rd_depth);

   assign hq_ready = (state == trans_pkg::ST_IDLE);
   assign rsp_valid = (state == trans_pkg::ST_RESP);
   assign busy = (state != trans_pkg::ST_IDLE);

   assign rd_en = (state == trans_pkg::ST_PROBE);
   assign rd_addr = cur_hash[trans_pkg::TABLE_SIZE_LOG2-1:0];

   assign wr_en = (state == trans_pkg::ST_DECIDE) && (cur_op == trans_pkg::OP_STORE) && replace;
   assign wr_addr = cur_hash[trans_pkg::TABLE_SIZE_LOG2-1:0];
   assign wr_tag = cur_hash;
   assign wr_eval = cur_eval;
   assign wr_depth = cur_depth;
   assign wr_flag = cur_flag;

   // ========================================
   // State machine
   // ========================================

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= trans_pkg::ST_IDLE;
      else
      begin
         case (state)
            trans_pkg::ST_IDLE:
               if (hq_valid) state <= trans_pkg::ST_PROBE;
            trans_pkg::ST_PROBE:
               state <= trans_pkg::ST_DECIDE;   // Table read in flight
            trans_pkg::ST_DECIDE:
               state <= (cur_op == trans_pkg::OP_LOOKUP) ? trans_pkg::ST_RESP
                                                         : trans_pkg::ST_IDLE;
            trans_pkg::ST_RESP:
               if (rsp_ready) state <= trans_pkg::ST_IDLE;
            default:
               state <= trans_pkg::ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (hq_valid && hq_ready)
      begin
         cur_op <= hq_op;
         cur_hash <= hq_hash;
         cur_eval <= hq_eval;
         cur_depth <= hq_depth;
         cur_flag <= hq_flag;
      end
      if (state == trans_pkg::ST_DECIDE && cur_op == trans_pkg::OP_LOOKUP)
      begin
         rsp_hit <= hit;
         rsp_hash <= cur_hash;
         rsp_eval <= hit ? rd_eval : '0;
         rsp_depth <= hit ? rd_depth : 8'd0;
         rsp_flag <= hit ? rd_flag : trans_pkg::FLAG_NONE;
      end
   end

endmodule

//--- hw/trans_pkg.sv
package trans_pkg;

   // ========================================
   // Widths and table geometry
   // ========================================

   localparam int BOARD_WIDTH = 256;           // 64 squares of 4 bits
   localparam int SIDE_WIDTH = 32;             // Board word fed to each hash lane
   localparam int HASH_LANES = BOARD_WIDTH / SIDE_WIDTH;
   localparam int EVAL_WIDTH = 16;

   localparam int TABLE_SIZE_LOG2 = 6;
   localparam int TABLE_SIZE = 1 << TABLE_SIZE_LOG2;

   // ========================================
   // Encodings
   // ========================================

   typedef enum logic
   {
      OP_LOOKUP,
      OP_STORE
   } trans_op_e;

   typedef enum logic [1:0]
   {
      FLAG_NONE,
      FLAG_EXACT,
      FLAG_LOWER,
      FLAG_UPPER
   } bound_flag_e;

   typedef enum logic [1:0]
   {
      ST_IDLE,
      ST_PROBE,
      ST_DECIDE,
      ST_RESP
   } ctrl_state_e;

   // Zero maps to zero, which is harmless for a hash key
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

endpackage

//--- hw/trans_top.sv
`timescale 1ns/1ps

module trans_top
(
   input  logic                                clk,
   input  logic                                reset,

   input  logic                                req_valid,
   output logic                                req_ready,
   input  trans_pkg::trans_op_e                req_op,
   input  logic [trans_pkg::BOARD_WIDTH-1:0]   req_board,
   input  logic                                req_white_to_move,
   input  logic [3:0]                          req_castle_mask,
   input  logic [3:0]                          req_en_passant_col,
   input  logic [trans_pkg::EVAL_WIDTH-1:0]    req_eval,
   input  logic [7:0]                          req_depth,
   input  trans_pkg::bound_flag_e              req_flag,

   output logic                                rsp_valid,
   input  logic                                rsp_ready,
   output logic                                rsp_hit,
   output logic [31:0]                         rsp_hash,
   output logic [trans_pkg::EVAL_WIDTH-1:0]    rsp_eval,
   output logic [7:0]                          rsp_depth,
   output trans_pkg::bound_flag_e              rsp_flag,

   output logic                                idle
);

   // Hasher to controller
   logic hq_valid, hq_ready;
   trans_pkg::trans_op_e hq_op;
   logic [31:0] hq_hash;
   logic [trans_pkg::EVAL_WIDTH-1:0] hq_eval;
   logic [7:0] hq_depth;
   trans_pkg::bound_flag_e hq_flag;

   // Controller to table
   logic rd_en, rd_valid;
   logic [trans_pkg::TABLE_SIZE_LOG2-1:0] rd_addr, wr_addr;
   logic [31:0] rd_tag, wr_tag;
   logic [trans_pkg::EVAL_WIDTH-1:0] rd_eval, wr_eval;
   logic [7:0] rd_depth, wr_depth;
   trans_pkg::bound_flag_e rd_flag, wr_flag;
   logic wr_en;

   logic hash_busy, ctrl_busy;

   assign idle = ~(hash_busy | ctrl_busy);

   pos_hash hasher
   (
      .clk(clk), .reset(reset),
      .in_valid(req_valid), .in_ready(req_ready), .in_op(req_op), .in_board(req_board),
      .in_white_to_move(req_white_to_move), .in_castle_mask(req_castle_mask),
      .in_en_passant_col(req_en_passant_col), .in_eval(req_eval), .in_depth(req_depth),
      .in_flag(req_flag),
      .out_valid(hq_valid), .out_ready(hq_ready), .out_op(hq_op), .out_hash(hq_hash),
      .out_eval(hq_eval), .out_depth(hq_depth), .out_flag(hq_flag),
      .busy(hash_busy)
   );

   trans_ctrl ctrl
   (
      .clk(clk), .reset(reset),
      .hq_valid(hq_valid), .hq_ready(hq_ready), .hq_op(hq_op), .hq_hash(hq_hash),
      .hq_eval(hq_eval), .hq_depth(hq_depth), .hq_flag(hq_flag),
      .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_hit(rsp_hit), .rsp_hash(rsp_hash),
      .rsp_eval(rsp_eval), .rsp_depth(rsp_depth), .rsp_flag(rsp_flag),
      .rd_en(rd_en), .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_tag(rd_tag),
      .rd_eval(rd_eval), .rd_depth(rd_depth), .rd_flag(rd_flag),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_tag(wr_tag), .wr_eval(wr_eval),
      .wr_depth(wr_depth), .wr_flag(wr_flag),
      .busy(ctrl_busy)
   );

   table_ram tbl
   (
      .clk(clk), .reset(reset),
      .rd_en(rd_en), .rd_addr(rd_addr), .rd_valid(rd_valid), .rd_tag(rd_tag),
      .rd_eval(rd_eval), .rd_depth(rd_depth), .rd_flag(rd_flag),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_tag(wr_tag), .wr_eval(wr_eval),
      .wr_depth(wr_depth), .wr_flag(wr_flag)
   );

endmodule

//--- project.f
hw/trans_pkg.sv
hw/pos_hash.sv
hw/table_ram.sv
hw/trans_ctrl.sv
hw/trans_top.sv
test/trans_check.sv
test/trans_assert.sv
test/trans_tb.sv

//--- test/trans_assert.sv
`timescale 1ns/1ps

module trans_assert
(
   input logic                                clk,
   input logic                                reset,
   input logic                                req_valid,
   input logic                                req_ready,
   input trans_pkg::trans_op_e                req_op,
   input logic [trans_pkg::BOARD_WIDTH-1:0]   req_board,
   input logic                                req_white_to_move,
   input logic [3:0]                          req_castle_mask,
   input logic [3:0]                          req_en_passant_col,
   input logic [trans_pkg::EVAL_WIDTH-1:0]    req_eval,
   input logic [7:0]                          req_depth,
   input trans_pkg::bound_flag_e              req_flag,
   input logic                                rsp_valid,
   input logic                                rsp_ready,
   input logic                                rsp_hit,
   input logic [31:0]                         rsp_hash,
   input logic [trans_pkg::EVAL_WIDTH-1:0]    rsp_eval,
   input logic [7:0]                          rsp_depth,
   input trans_pkg::bound_flag_e              rsp_flag,
   input logic                                idle
);

   assert property (@(posedge clk) disable iff (reset)
      (req_valid && !req_ready) |=> (req_valid && $stable({req_op, req_board,
         req_white_to_move, req_castle_mask, req_en_passant_col, req_eval, req_depth,
         req_flag})))
      else $error("request changed while waiting for req_ready");

   assert property (@(posedge clk) disable iff (reset)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable({rsp_hit, rsp_hash, rsp_eval,
         rsp_depth, rsp_flag})))
      else $error("response changed while waiting for rsp_ready");

   // One reset edge is enough to empty the pipe and the controller
   assert property (@(posedge clk) reset |=> (!rsp_valid && idle))
      else $error("rsp_valid high or idle low after reset");

endmodule

bind trans_top trans_assert assertions (.*);

//--- test/trans_check.sv
`timescale 1ns/1ps

module trans_check
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                req_valid,
   input  logic                                req_ready,
   input  trans_pkg::trans_op_e                req_op,
   input  logic [trans_pkg::BOARD_WIDTH-1:0]   req_board,
   input  logic                                req_white_to_move,
   input  logic [3:0]                          req_castle_mask,
   input  logic [3:0]                          req_en_passant_col,
   input  logic [trans_pkg::EVAL_WIDTH-1:0]    req_eval,
   input  logic [7:0]                          req_depth,
   input  trans_pkg::bound_flag_e              req_flag,
   input  logic                                exp_hit,       // Hit expected by the stimulus table
   input  logic                                rsp_valid,
   input  logic                                rsp_ready,
   input  logic                                rsp_hit,
   input  logic [31:0]                         rsp_hash,
   input  logic [trans_pkg::EVAL_WIDTH-1:0]    rsp_eval,
   input  logic [7:0]                          rsp_depth,
   input  trans_pkg::bound_flag_e              rsp_flag,
   output int                                  errors,
   output int                                  pending
);

   typedef struct packed
   {
      logic table_hit;
      logic hit;
      logic [31:0] key;
      logic [trans_pkg::EVAL_WIDTH-1:0] eval;
      logic [7:0] depth;
      trans_pkg::bound_flag_e flag;
   } expect_t;

   expect_t expected [$];
   int error_count = 0;
   int pending_count = 0;

   // Model of the direct-mapped table
   logic [trans_pkg::TABLE_SIZE-1:0] m_valid;
   logic [31:0] m_tag [trans_pkg::TABLE_SIZE];
   logic [trans_pkg::EVAL_WIDTH-1:0] m_eval [trans_pkg::TABLE_SIZE];
   logic [7:0] m_depth [trans_pkg::TABLE_SIZE];
   trans_pkg::bound_flag_e m_flag [trans_pkg::TABLE_SIZE];

   assign errors = error_count;
   assign pending = pending_count;

   function automatic logic [31:0] scramble32(input logic [31:0] v);
      logic [31:0] t;
      t = v ^ (v << 13);
      t = t ^ (t >> 17);
      return t ^ (t << 5);
   endfunction

   function automatic logic [31:0] position_key(input logic [trans_pkg::BOARD_WIDTH-1:0] board,
                                                input logic white, input logic [3:0] castle,
                                                input logic [3:0] ep);
      logic [31:0] sum;
      sum = 32'd0;
      for (int i = 0; i < trans_pkg::HASH_LANES; i++)
      begin
         if (i % 2 == 0)
            sum = sum + scramble32(board[i*trans_pkg::SIDE_WIDTH +: trans_pkg::SIDE_WIDTH]);
         else
            sum = sum - scramble32(board[i*trans_pkg::SIDE_WIDTH +: trans_pkg::SIDE_WIDTH]);
      end
      sum = sum + {28'd0, castle ^ ep};
      return white ? scramble32(sum) : sum;
   endfunction

   task automatic compare_field(input string name, input logic [31:0] want,
                                input logic [31:0] got);
      if (want !== got)
      begin
         $display("ERR %0t %s expected %h got %h", $time, name, want, got);
         error_count++;
      end
   endtask

   always @(posedge clk)
   begin : model
      expect_t e;
      logic [31:0] key;
      logic [trans_pkg::TABLE_SIZE_LOG2-1:0] idx;
      logic found;
      if (reset)
      begin
         m_valid = '0;
         expected.delete();
      end
      else
      begin
         // Pop first, so a lookup accepted on this edge joins the back of the queue
         if (rsp_valid && rsp_ready)
         begin
            if (expected.size() == 0)
            begin
               $display("%0t: a response arrived with no lookup outstanding", $time);
               error_count++;
            end
            else
            begin
               e = expected.pop_front();
               compare_field("rsp_hit", {31'd0, e.hit}, {31'd0, rsp_hit});
               compare_field("rsp_hit (table)", {31'd0, e.table_hit}, {31'd0, rsp_hit});
               compare_field("rsp_hash", e.key, rsp_hash);
               compare_field("rsp_eval", {16'd0, e.eval}, {16'd0, rsp_eval});
               compare_field("rsp_depth", {24'd0, e.depth}, {24'd0, rsp_depth});
               compare_field("rsp_flag", {30'd0, e.flag}, {30'd0, rsp_flag});
            end
         end
         if (req_valid && req_ready)
         begin
            key = position_key(req_board, req_white_to_move, req_castle_mask,
                               req_en_passant_col);
            idx = key[trans_pkg::TABLE_SIZE_LOG2-1:0];
            found = m_valid[idx] && (m_tag[idx] == key);
            if (req_op == trans_pkg::OP_LOOKUP)
            begin
               e.table_hit = exp_hit;
               e.hit = found;
               e.key = key;
               e.eval = found ? m_eval[idx] : '0;
               e.depth = found ? m_depth[idx] : 8'd0;
               e.flag = found ? m_flag[idx] : trans_pkg::FLAG_NONE;
               expected.push_back(e);
            end
            else if (!found || req_depth >= m_depth[idx])
            begin
               m_valid[idx] = 1'b1;
               m_tag[idx] = key;
               m_eval[idx] = req_eval;
               m_depth[idx] = req_depth;
               m_flag[idx] = req_flag;
            end
         end
      end
      pending_count = expected.size();
   end

endmodule

//--- test/trans_tb.sv
`timescale 1ns/1ps

module trans_tb;

   typedef struct packed
   {
      trans_pkg::trans_op_e op;
      logic [7:0] board_seed;
      logic alias_pos;                          // Flip board bit 31, keeping the index
      logic white;
      logic [3:0] castle;
      logic [3:0] ep;
      logic [trans_pkg::EVAL_WIDTH-1:0] eval;
      logic [7:0] depth;
      trans_pkg::bound_flag_e flag;
      logic exp_hit;
   } row_t;

   logic clk = 1'b0;
   logic reset;
   logic req_valid, req_ready;
   trans_pkg::trans_op_e req_op;
   logic [trans_pkg::BOARD_WIDTH-1:0] req_board;
   logic req_white_to_move;
   logic [3:0] req_castle_mask, req_en_passant_col;
   logic [trans_pkg::EVAL_WIDTH-1:0] req_eval;
   logic [7:0] req_depth;
   trans_pkg::bound_flag_e req_flag;
   logic rsp_valid, rsp_ready, rsp_hit;
   logic [31:0] rsp_hash;
   logic [trans_pkg::EVAL_WIDTH-1:0] rsp_eval;
   logic [7:0] rsp_depth;
   trans_pkg::bound_flag_e rsp_flag;
   logic idle;
   logic exp_hit;
   int errors, pending;
   int tb_errors;
   int wait_cycles;
   integer seed;
   row_t rows [$];

   trans_top UUT (.*);
   trans_check chk (.*);

   always #2 clk = ~clk;

   always @(negedge clk)
      rsp_ready = ($random(seed) % 3) != 0;      // Low about a third of the time

   function automatic logic [trans_pkg::BOARD_WIDTH-1:0] make_board(input logic [7:0] board_seed,
                                                                    input logic alias_pos);
      integer s;
      logic [trans_pkg::BOARD_WIDTH-1:0] b;
      s = 32'h7726_c593 ^ {24'd0, board_seed};
      for (int i = 0; i < trans_pkg::HASH_LANES; i++)
         b[i*trans_pkg::SIDE_WIDTH +: trans_pkg::SIDE_WIDTH] = $random(s);
      // Bit 31 of word 0 never reaches the low six bits after the xorshift
      b[31] = b[31] ^ alias_pos;
      return b;
   endfunction

   task automatic add_row(input logic store, input logic [7:0] board_seed, input logic alias_pos,
                          input logic white, input logic [3:0] castle, input logic [3:0] ep,
                          input logic [15:0] eval, input logic [7:0] depth,
                          input trans_pkg::bound_flag_e flag, input logic hit);
      row_t r;
      r.op = store ? trans_pkg::OP_STORE : trans_pkg::OP_LOOKUP;
      r.board_seed = board_seed;
      r.alias_pos = alias_pos;
      r.white = white;
      r.castle = castle;
      r.ep = ep;
      r.eval = eval;
      r.depth = depth;
      r.flag = flag;
      r.exp_hit = hit;
      rows.push_back(r);
   endtask

   // ========================================
   // Stimulus table
   // ========================================

   task automatic load_table();
      // store, seed, alias, white, castle, ep, eval, depth, flag, hit
      add_row(1'b0, 8'h11, 1'b0, 1'b0, 4'hf, 4'h0, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b0);
      add_row(1'b0, 8'h22, 1'b0, 1'b1, 4'h5, 4'h2, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b0);
      add_row(1'b0, 8'h44, 1'b0, 1'b0, 4'h3, 4'hc, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b0);
      add_row(1'b1, 8'h11, 1'b0, 1'b0, 4'hf, 4'h0, 16'h0064, 8'd5, trans_pkg::FLAG_EXACT, 1'b0);
      add_row(1'b0, 8'h11, 1'b0, 1'b0, 4'hf, 4'h0, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b1);
      add_row(1'b1, 8'h11, 1'b0, 1'b0, 4'hf, 4'h0, 16'h00c8, 8'd3, trans_pkg::FLAG_LOWER, 1'b0);
      add_row(1'b0, 8'h11, 1'b0, 1'b0, 4'hf, 4'h0, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b1);
      add_row(1'b1, 8'h11, 1'b0, 1'b0, 4'hf, 4'h0, 16'h012c, 8'd5, trans_pkg::FLAG_UPPER, 1'b0);
      add_row(1'b0, 8'h11, 1'b0, 1'b0, 4'hf, 4'h0, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b1);
      add_row(1'b1, 8'h11, 1'b0, 1'b0, 4'hf, 4'h0, 16'hff9c, 8'd9, trans_pkg::FLAG_LOWER, 1'b0);
      add_row(1'b0, 8'h11, 1'b0, 1'b0, 4'hf, 4'h0, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b1);
      add_row(1'b0, 8'h11, 1'b1, 1'b0, 4'hf, 4'h0, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b0);
      add_row(1'b1, 8'h11, 1'b1, 1'b0, 4'hf, 4'h0, 16'h0007, 8'd1, trans_pkg::FLAG_EXACT, 1'b0);
      add_row(1'b0, 8'h11, 1'b1, 1'b0, 4'hf, 4'h0, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b1);
      add_row(1'b0, 8'h11, 1'b0, 1'b0, 4'hf, 4'h0, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b0);
      add_row(1'b1, 8'h22, 1'b0, 1'b1, 4'h5, 4'h2, 16'hffce, 8'd4, trans_pkg::FLAG_EXACT, 1'b0);
      add_row(1'b0, 8'h22, 1'b0, 1'b1, 4'h5, 4'h2, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b1);
      add_row(1'b0, 8'h22, 1'b0, 1'b0, 4'h5, 4'h2, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b0);
      add_row(1'b0, 8'h33, 1'b0, 1'b1, 4'h0, 4'h7, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b0);
      add_row(1'b1, 8'h33, 1'b0, 1'b1, 4'h0, 4'h7, 16'h0040, 8'd2, trans_pkg::FLAG_UPPER, 1'b0);
      add_row(1'b0, 8'h33, 1'b0, 1'b1, 4'h0, 4'h7, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b1);
      add_row(1'b0, 8'h33, 1'b0, 1'b1, 4'h0, 4'h7, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b1);
      add_row(1'b0, 8'h44, 1'b0, 1'b0, 4'h3, 4'hc, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b0);
      add_row(1'b0, 8'h33, 1'b0, 1'b1, 4'h0, 4'h7, 16'h0000, 8'd0, trans_pkg::FLAG_NONE, 1'b1);
   endtask

   task automatic drive_request(input row_t r);
      logic accepted;
      req_valid = 1'b1;
      req_op = r.op;
      req_board = make_board(r.board_seed, r.alias_pos);
      req_white_to_move = r.white;
      req_castle_mask = r.castle;
      req_en_passant_col = r.ep;
      req_eval = r.eval;
      req_depth = r.depth;
      req_flag = r.flag;
      exp_hit = r.exp_hit;
      accepted = 1'b0;
      while (!accepted)
      begin
         accepted = req_ready;                  // Ready now means a transfer on the next edge
         @(negedge clk);
      end
   endtask

   initial
   begin
      seed = 32'h7726_c593;
      reset = 1'b1;
      req_valid = 1'b0;
      req_op = trans_pkg::OP_LOOKUP;
      req_board = '0;
      req_white_to_move = 1'b0;
      req_castle_mask = 4'd0;
      req_en_passant_col = 4'd0;
      req_eval = '0;
      req_depth = 8'd0;
      req_flag = trans_pkg::FLAG_NONE;
      rsp_ready = 1'b0;
      exp_hit = 1'b0;
      tb_errors = 0;
      load_table();
      repeat (5) @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < rows.size(); i++)
         drive_request(rows[i]);
      req_valid = 1'b0;
      while (pending != 0)
         @(negedge clk);
      wait_cycles = 0;
      while (!idle && wait_cycles < 20)
      begin
         @(negedge clk);
         wait_cycles++;
      end
      if (!idle)
      begin
         $display("idle stayed low after the last response");
         tb_errors++;
      end
      $display("Error counts: %0d from checker, %0d from testbench", errors, tb_errors);
      if (errors == 0 && tb_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   // ========================================
   // Watchdog
   // ========================================

   initial
   begin
      @(negedge clk);
      repeat (rows.size() * 200 + 1000) @(posedge clk);
      $display("Timeout: the run did not finish in %0d cycles", rows.size() * 200 + 1000);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule
